// ==== cache_sim_wrapper.f ====
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/write_through_buf.sv
design/backend_arbiter.sv
design/backend_ram.sv
design/cache_ctrl.sv
design/cache_sim_wrapper.sv
tb/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module cache_tb -f cache_sim_wrapper.f

sim_output=$(./obj_dir/Vcache_tb || true)
echo "$sim_output"

if echo "$sim_output" | grep -q "Result: PASSED"; then
   exit 0
fi
exit 1

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

   localparam int ADDR_W = cache_pkg::DEF_ADDR_W;
   localparam int DATA_W = cache_pkg::DEF_DATA_W;
   localparam int NBYTES = DATA_W / 8;
   localparam int WORDS  = 2 ** cache_pkg::DEF_WORD_OFFSET_W;
   // Roughly four times the cycles of all tests together
   localparam int TIMEOUT_CYCLES = 20000;
   // Read hit ack two cycles after the request plus the hold cycle of access
   localparam int HIT_CYCLES = 3;

   logic              clk_i;
   logic              rst_i;
   logic              req_i;
   logic [ADDR_W-1:0] addr_i;
   logic [DATA_W-1:0] wdata_i;
   logic [NBYTES-1:0] wstrb_i;
   logic              invalidate_i;
   logic [DATA_W-1:0] rdata_o;
   logic              ack_o;
   logic              wtb_empty_o;

   // Byte-wide reference memory keyed by byte address
   logic [7:0] ref_mem [int];
   integer     seed;
   int         cycle_count;
   int         error_count;

   cache_sim_wrapper #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .NLINES_W     (cache_pkg::DEF_NLINES_W),
      .WORD_OFFSET_W(cache_pkg::DEF_WORD_OFFSET_W),
      .WTBUF_DEPTH_W(cache_pkg::DEF_WTBUF_DEPTH_W)
   ) cache_sim_wrapper_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (req_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .invalidate_i(invalidate_i),
      .rdata_o     (rdata_o),
      .ack_o       (ack_o),
      .wtb_empty_o (wtb_empty_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   initial begin
      cache_pkg::ctrl_state_t st;
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk_i);
         cycle_count++;
      end
      st = cache_sim_wrapper_inst.cache_ctrl_inst.state;
      $display("Timeout after %0d cycles, controller in state %s", cycle_count, st.name());
      $display("Result: FAILED");
      $fatal(1, "Simulation did not finish in time");
   end

   function automatic logic [DATA_W-1:0] rand_word();
      rand_word = $random(seed);
   endfunction

   // Expected word built from the bytes written so far
   function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] w;
      int                base;
      w    = '0;
      base = int'(addr) & ~(NBYTES - 1);
      for (int b = 0; b < NBYTES; b++) begin
         if (ref_mem.exists(base + b)) begin
            w[b*8 +: 8] = ref_mem[base + b];
         end
      end
      return w;
   endfunction

   function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                       input logic [DATA_W-1:0] data,
                                       input logic [NBYTES-1:0] strb);
      int base;
      base = int'(addr) & ~(NBYTES - 1);
      for (int b = 0; b < NBYTES; b++) begin
         if (strb[b]) begin
            ref_mem[base + b] = data[b*8 +: 8];
         end
      end
   endfunction

   // Random window of 4 tags x 4 lines x 4 words
   function automatic logic [ADDR_W-1:0] window_addr(input logic [5:0] k);
      return {2'b10, k[5:4], 2'b00, k[3:2], k[1:0], 2'b00};
   endfunction

   task automatic expect_eq(input string test_name,
                            input logic [DATA_W-1:0] expected,
                            input logic [DATA_W-1:0] actual);
      if (expected !== actual) begin
         error_count++;
         $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
         $display("Result: FAILED");
         $fatal(1, "Mismatch in test %s", test_name);
      end
   endtask

   task automatic wait_ack();
      do begin
         @(posedge clk_i);
         #1;
      end while (!ack_o);
   endtask

   task automatic wait_drain();
      while (!wtb_empty_o) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   // One front-end transfer with the request held through the ack cycle
   task automatic access(input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data,
                         input logic [NBYTES-1:0] strb,
                         output logic [DATA_W-1:0] rdata);
      req_i   = 1'b1;
      addr_i  = addr;
      wdata_i = data;
      wstrb_i = strb;
      wait_ack();
      rdata = rdata_o;
      @(posedge clk_i);
      #1;
      req_i   = 1'b0;
      wstrb_i = '0;
   endtask

   task automatic do_write(input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data,
                           input logic [NBYTES-1:0] strb);
      logic [DATA_W-1:0] unused_rd;
      access(addr, data, strb, unused_rd);
      model_write(addr, data, strb);
   endtask

   task automatic do_read(input string test_name, input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] rd;
      access(addr, '0, '0, rd);
      expect_eq(test_name, model_word(addr), rd);
   endtask

   // Checked read that also reports how many cycles the transfer took
   task automatic timed_read(input string test_name,
                             input logic [ADDR_W-1:0] addr,
                             output int cycles);
      int start;
      start = cycle_count;
      do_read(test_name, addr);
      cycles = cycle_count - start;
   endtask

   task automatic pulse_invalidate();
      invalidate_i = 1'b1;
      @(posedge clk_i);
      #1;
      invalidate_i = 1'b0;
   endtask

   task automatic reset_values();
      expect_eq("reset", DATA_W'(1'b0), DATA_W'(ack_o));
      expect_eq("reset", DATA_W'(1'b1), DATA_W'(wtb_empty_o));
      do_write(12'h040, rand_word(), '1);
      do_read("reset", 12'h040);
   endtask

   task automatic byte_strobe_merge();
      do_write(12'h104, rand_word(), '1);
      do_read("byte_strobes", 12'h104);
      do_write(12'h104, rand_word(), 4'b0001);
      do_write(12'h104, rand_word(), 4'b0110);
      do_write(12'h104, rand_word(), 4'b1000);
      do_read("byte_strobes", 12'h104);
      pulse_invalidate();
      // The bytes now come back from the backend on a miss
      do_read("byte_strobes", 12'h104);
   endtask

   task automatic line_fill();
      logic [ADDR_W-1:0] a;
      int                cycles;
      a = 12'h280;
      for (int w = 0; w < WORDS; w++) begin
         do_write(a, rand_word(), '1);
         a = a + ADDR_W'(NBYTES);
      end
      wait_drain();
      // Start in the middle of the line
      do_read("line_fill", 12'h288);
      // The rest of the line is resident after the one fill
      timed_read("line_fill", 12'h280, cycles);
      expect_eq("line_fill", DATA_W'(HIT_CYCLES), DATA_W'(cycles));
      timed_read("line_fill", 12'h284, cycles);
      expect_eq("line_fill", DATA_W'(HIT_CYCLES), DATA_W'(cycles));
      timed_read("line_fill", 12'h28c, cycles);
      expect_eq("line_fill", DATA_W'(HIT_CYCLES), DATA_W'(cycles));
   endtask

   task automatic conflict_misses();
      do_write(12'h334, rand_word(), '1);
      do_write(12'h734, rand_word(), '1);
      do_write(12'hb34, rand_word(), '1);
      for (int r = 0; r < 3; r++) begin
         do_read("conflict", 12'h334);
         do_read("conflict", 12'h734);
         if (r == 1) begin
            do_write(12'h734, rand_word(), 4'b0011);
            do_write(12'hb34, rand_word(), 4'b1100);
         end
         do_read("conflict", 12'h334);
         do_read("conflict", 12'hb34);
         do_read("conflict", 12'h734);
      end
   endtask

   task automatic invalidate_drain();
      logic [ADDR_W-1:0] a;
      int                cycles;
      a = 12'h500;
      for (int i = 0; i < 6; i++) begin
         do_write(a, rand_word(), '1);
         a = a + ADDR_W'(NBYTES);
      end
      expect_eq("invalidate_drain", DATA_W'(1'b0), DATA_W'(wtb_empty_o));
      wait_drain();
      a = 12'h500;
      for (int i = 0; i < 6; i++) begin
         do_read("invalidate_drain", a);
         pulse_invalidate();
         // Every line is invalid again so this read misses
         timed_read("invalidate_drain", a, cycles);
         expect_eq("invalidate_drain", DATA_W'(1'b1), DATA_W'(cycles > HIT_CYCLES));
         a = a + ADDR_W'(NBYTES);
      end
      do_read("invalidate_drain", 12'h508);
      do_write(12'h508, rand_word(), 4'b0101);
      pulse_invalidate();
      do_read("invalidate_drain", 12'h508);
   endtask

   task automatic random_mix();
      logic [DATA_W-1:0] r;
      logic [NBYTES-1:0] strb;
      // Every byte of the window gets a known value first
      for (int k = 0; k < 64; k++) begin
         do_write(window_addr(6'(k)), rand_word(), '1);
      end
      for (int n = 0; n < 300; n++) begin
         r = rand_word();
         if (r[0]) begin
            do_read("random", window_addr(r[13:8]));
         end else begin
            strb = r[NBYTES+3:4];
            if (strb == '0) begin
               strb = '1;
            end
            do_write(window_addr(r[13:8]), rand_word(), strb);
         end
      end
   endtask

   initial begin
      seed         = 64089;
      error_count  = 0;
      rst_i        = 1'b1;
      req_i        = 1'b0;
      addr_i       = '0;
      wdata_i      = '0;
      wstrb_i      = '0;
      invalidate_i = 1'b0;
      repeat (3) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      reset_values();
      byte_strobe_merge();
      line_fill();
      conflict_misses();
      invalidate_drain();
      random_mix();

      if (error_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== design/cache_sim_wrapper.sv ====
`timescale 1ns/1ps

module cache_sim_wrapper #(
   parameter int ADDR_W        = cache_pkg::DEF_ADDR_W,
   parameter int DATA_W        = cache_pkg::DEF_DATA_W,
   parameter int NLINES_W      = cache_pkg::DEF_NLINES_W,
   parameter int WORD_OFFSET_W = cache_pkg::DEF_WORD_OFFSET_W,
   parameter int WTBUF_DEPTH_W = cache_pkg::DEF_WTBUF_DEPTH_W
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                req_i,
   input  logic [ADDR_W-1:0]   addr_i,
   input  logic [DATA_W-1:0]   wdata_i,
   input  logic [DATA_W/8-1:0] wstrb_i,
   input  logic                invalidate_i,
   output logic [DATA_W-1:0]   rdata_o,
   output logic                ack_o,
   output logic                wtb_empty_o
);

   localparam int NBYTES    = DATA_W / 8;
   localparam int BOFF_W    = $clog2(NBYTES);
   localparam int TAG_W     = ADDR_W - NLINES_W - WORD_OFFSET_W - BOFF_W;
   localparam int DADDR_W   = NLINES_W + WORD_OFFSET_W;
   localparam int BE_ADDR_W = ADDR_W - BOFF_W;

   // Tag and data store
   logic [NLINES_W-1:0] tag_idx;
   logic                tag_we;
   logic [TAG_W-1:0]    tag_wr_tag;
   logic [TAG_W-1:0]    tag_rd_tag;
   logic                tag_rd_valid;
   logic                invalidate;
   logic [DADDR_W-1:0]  data_addr;
   logic                data_we;
   logic [NBYTES-1:0]   data_wstrb;
   logic [DATA_W-1:0]   data_wdata;
   logic [DATA_W-1:0]   data_rd;

   // Write buffer
   logic                wtb_push;
   logic                wtb_pop;
   logic                wtb_full;
   logic [ADDR_W-1:0]   wtb_addr;
   logic [DATA_W-1:0]   wtb_data;
   logic [NBYTES-1:0]   wtb_strb;
   logic [ADDR_W-1:0]   wtb_head_addr;
   logic [DATA_W-1:0]   wtb_head_data;
   logic [NBYTES-1:0]   wtb_head_strb;

   // Line fill and backend
   logic                fill_req;
   logic [ADDR_W-1:0]   fill_addr;
   logic                fill_ack;
   logic [DATA_W-1:0]   fill_rdata;
   logic                be_req;
   logic                be_ack;
   logic [BE_ADDR_W-1:0] be_addr;
   logic [DATA_W-1:0]   be_wdata;
   logic [NBYTES-1:0]   be_wstrb;
   logic [DATA_W-1:0]   be_rdata;

   cache_ctrl #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .NLINES_W     (NLINES_W),
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) cache_ctrl_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req_i         (req_i),
      .addr_i        (addr_i),
      .wdata_i       (wdata_i),
      .wstrb_i       (wstrb_i),
      .invalidate_i  (invalidate_i),
      .tag_rd_tag_i  (tag_rd_tag),
      .tag_rd_valid_i(tag_rd_valid),
      .data_rd_i     (data_rd),
      .wtb_full_i    (wtb_full),
      .wtb_empty_i   (wtb_empty_o),
      .fill_ack_i    (fill_ack),
      .fill_rdata_i  (fill_rdata),
      .rdata_o       (rdata_o),
      .ack_o         (ack_o),
      .tag_idx_o     (tag_idx),
      .tag_we_o      (tag_we),
      .tag_wr_tag_o  (tag_wr_tag),
      .data_addr_o   (data_addr),
      .data_we_o     (data_we),
      .data_wstrb_o  (data_wstrb),
      .data_wdata_o  (data_wdata),
      .wtb_push_o    (wtb_push),
      .wtb_addr_o    (wtb_addr),
      .wtb_data_o    (wtb_data),
      .wtb_strb_o    (wtb_strb),
      .fill_req_o    (fill_req),
      .fill_addr_o   (fill_addr),
      .invalidate_o  (invalidate)
   );

   cache_tag_store #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .NLINES_W     (NLINES_W),
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) cache_tag_store_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .idx_i       (tag_idx),
      .we_i        (tag_we),
      .wr_tag_i    (tag_wr_tag),
      .invalidate_i(invalidate),
      .rd_tag_o    (tag_rd_tag),
      .rd_valid_o  (tag_rd_valid)
   );

   cache_data_store #(
      .DATA_W       (DATA_W),
      .NLINES_W     (NLINES_W),
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) cache_data_store_inst (
      .clk_i  (clk_i),
      .addr_i (data_addr),
      .we_i   (data_we),
      .wstrb_i(data_wstrb),
      .wdata_i(data_wdata),
      .rd_o   (data_rd)
   );

   write_through_buf #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .WTBUF_DEPTH_W(WTBUF_DEPTH_W)
   ) write_through_buf_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .push_i     (wtb_push),
      .addr_i     (wtb_addr),
      .data_i     (wtb_data),
      .strb_i     (wtb_strb),
      .pop_i      (wtb_pop),
      .full_o     (wtb_full),
      .empty_o    (wtb_empty_o),
      .head_addr_o(wtb_head_addr),
      .head_data_o(wtb_head_data),
      .head_strb_o(wtb_head_strb)
   );

   backend_arbiter #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) backend_arbiter_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .wtb_empty_i (wtb_empty_o),
      .wtb_addr_i  (wtb_head_addr),
      .wtb_data_i  (wtb_head_data),
      .wtb_strb_i  (wtb_head_strb),
      .fill_req_i  (fill_req),
      .fill_addr_i (fill_addr),
      .be_ack_i    (be_ack),
      .be_rdata_i  (be_rdata),
      .wtb_pop_o   (wtb_pop),
      .fill_ack_o  (fill_ack),
      .fill_rdata_o(fill_rdata),
      .be_req_o    (be_req),
      .be_addr_o   (be_addr),
      .be_wdata_o  (be_wdata),
      .be_wstrb_o  (be_wstrb)
   );

   backend_ram #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) backend_ram_inst (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .req_i  (be_req),
      .addr_i (be_addr),
      .wdata_i(be_wdata),
      .wstrb_i(be_wstrb),
      .rdata_o(be_rdata),
      .ack_o  (be_ack)
   );

endmodule

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
   parameter int ADDR_W        = cache_pkg::DEF_ADDR_W,
   parameter int DATA_W        = cache_pkg::DEF_DATA_W,
   parameter int NLINES_W      = cache_pkg::DEF_NLINES_W,
   parameter int WORD_OFFSET_W = cache_pkg::DEF_WORD_OFFSET_W,
   localparam int NBYTES       = DATA_W / 8,
   localparam int BOFF_W       = $clog2(NBYTES),
   localparam int TAG_W        = ADDR_W - NLINES_W - WORD_OFFSET_W - BOFF_W
) (
   input  logic                              clk_i,
   input  logic                              rst_i,
   input  logic                              req_i,
   input  logic [ADDR_W-1:0]                 addr_i,
   input  logic [DATA_W-1:0]                 wdata_i,
   input  logic [NBYTES-1:0]                 wstrb_i,
   input  logic                              invalidate_i,
   input  logic [TAG_W-1:0]                  tag_rd_tag_i,
   input  logic                              tag_rd_valid_i,
   input  logic [DATA_W-1:0]                 data_rd_i,
   input  logic                              wtb_full_i,
   input  logic                              wtb_empty_i,
   input  logic                              fill_ack_i,
   input  logic [DATA_W-1:0]                 fill_rdata_i,
   output logic [DATA_W-1:0]                 rdata_o,
   output logic                              ack_o,
   output logic [NLINES_W-1:0]               tag_idx_o,
   output logic                              tag_we_o,
   output logic [TAG_W-1:0]                  tag_wr_tag_o,
   output logic [NLINES_W+WORD_OFFSET_W-1:0] data_addr_o,
   output logic                              data_we_o,
   output logic [NBYTES-1:0]                 data_wstrb_o,
   output logic [DATA_W-1:0]                 data_wdata_o,
   output logic                              wtb_push_o,
   output logic [ADDR_W-1:0]                 wtb_addr_o,
   output logic [DATA_W-1:0]                 wtb_data_o,
   output logic [NBYTES-1:0]                 wtb_strb_o,
   output logic                              fill_req_o,
   output logic [ADDR_W-1:0]                 fill_addr_o,
   output logic                              invalidate_o
);

   cache_pkg::ctrl_state_t state;

   logic [TAG_W-1:0]         req_tag;
   logic [NLINES_W-1:0]      req_idx;
   logic [WORD_OFFSET_W-1:0] req_word;
   logic [WORD_OFFSET_W-1:0] fill_cnt;
   logic                     fill_abort;
   logic                     is_write;
   logic                     hit;
   logic                     in_fill;

   // Request address split, held by the master until ack
   assign req_tag  = addr_i[ADDR_W-1 -: TAG_W];
   assign req_idx  = addr_i[BOFF_W+WORD_OFFSET_W +: NLINES_W];
   assign req_word = addr_i[BOFF_W +: WORD_OFFSET_W];
   assign is_write = |wstrb_i;
   assign hit      = tag_rd_valid_i && (tag_rd_tag_i == req_tag);
   assign in_fill  = (state == cache_pkg::FILL);

   assign tag_idx_o    = req_idx;
   assign tag_wr_tag_o = req_tag;
   // A fill cut by invalidate leaves the line invalid
   assign tag_we_o     = (state == cache_pkg::FILL_DONE) && !fill_abort;
   assign invalidate_o = invalidate_i;

   assign data_addr_o  = {req_idx, in_fill ? fill_cnt : req_word};
   assign data_we_o    = (state == cache_pkg::LOOKUP && is_write && hit && !wtb_full_i) ||
                         (in_fill && fill_ack_i);
   assign data_wstrb_o = in_fill ? {NBYTES{1'b1}} : wstrb_i;
   assign data_wdata_o = in_fill ? fill_rdata_i : wdata_i;

   // Every write goes to the buffer, hit or miss
   assign wtb_push_o = (state == cache_pkg::LOOKUP) && is_write;
   assign wtb_addr_o = addr_i;
   assign wtb_data_o = wdata_i;
   assign wtb_strb_o = wstrb_i;

   assign fill_req_o  = in_fill;
   assign fill_addr_o = {req_tag, req_idx, fill_cnt, {BOFF_W{1'b0}}};

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state      <= cache_pkg::IDLE;
         ack_o      <= 1'b0;
         fill_cnt   <= '0;
         fill_abort <= 1'b0;
      end else begin
         ack_o <= 1'b0;
         case (state)
            cache_pkg::IDLE: begin
               // req_i is still high in the ack cycle
               if (req_i && !ack_o) begin
                  state <= cache_pkg::LOOKUP;
               end
            end
            cache_pkg::LOOKUP: begin
               if (is_write) begin
                  if (!wtb_full_i) begin
                     ack_o <= 1'b1;
                     state <= cache_pkg::IDLE;
                  end
               end else if (hit) begin
                  ack_o <= 1'b1;
                  state <= cache_pkg::IDLE;
               end else begin
                  state <= cache_pkg::WAIT_WTB;
               end
            end
            cache_pkg::WAIT_WTB: begin
               // Backend must hold every pending write before the fill
               if (wtb_empty_i) begin
                  fill_cnt   <= '0;
                  fill_abort <= 1'b0;
                  state      <= cache_pkg::FILL;
               end
            end
            cache_pkg::FILL: begin
               if (invalidate_i) begin
                  fill_abort <= 1'b1;
               end
               if (fill_ack_i) begin
                  fill_cnt <= fill_cnt + 1'b1;
                  if (&fill_cnt) begin
                     state <= cache_pkg::FILL_DONE;
                  end
               end
            end
            cache_pkg::FILL_DONE: begin
               ack_o <= 1'b1;
               state <= cache_pkg::IDLE;
            end
            default: state <= cache_pkg::IDLE;
         endcase
      end
   end

   // Hit data from the store, miss data caught as the word passes by
   always_ff @(posedge clk_i) begin
      if (state == cache_pkg::LOOKUP) begin
         rdata_o <= data_rd_i;
      end else if (in_fill && fill_ack_i && (fill_cnt == req_word)) begin
         rdata_o <= fill_rdata_i;
      end
   end

endmodule

// ==== design/backend_ram.sv ====
`timescale 1ns/1ps

module backend_ram #(
   parameter int ADDR_W     = cache_pkg::DEF_ADDR_W,
   parameter int DATA_W     = cache_pkg::DEF_DATA_W,
   localparam int NBYTES    = DATA_W / 8,
   localparam int BE_ADDR_W = ADDR_W - $clog2(NBYTES)
) (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 req_i,
   input  logic [BE_ADDR_W-1:0] addr_i,
   input  logic [DATA_W-1:0]    wdata_i,
   input  logic [NBYTES-1:0]    wstrb_i,
   output logic [DATA_W-1:0]    rdata_o,
   output logic                 ack_o
);

   logic [DATA_W-1:0] mem [2**BE_ADDR_W];
   logic              accept;

   // No new request is taken while the previous ack is out
   assign accept = req_i && !ack_o;

   always_ff @(posedge clk_i) begin
      if (accept) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (wstrb_i[b]) begin
               mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
         end
         rdata_o <= mem[addr_i];
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= accept;
      end
   end

endmodule

// ==== design/backend_arbiter.sv ====
`timescale 1ns/1ps

module backend_arbiter #(
   parameter int ADDR_W   = cache_pkg::DEF_ADDR_W,
   parameter int DATA_W   = cache_pkg::DEF_DATA_W,
   localparam int BOFF_W  = $clog2(DATA_W / 8)
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     wtb_empty_i,
   input  logic [ADDR_W-1:0]        wtb_addr_i,
   input  logic [DATA_W-1:0]        wtb_data_i,
   input  logic [DATA_W/8-1:0]      wtb_strb_i,
   input  logic                     fill_req_i,
   input  logic [ADDR_W-1:0]        fill_addr_i,
   input  logic                     be_ack_i,
   input  logic [DATA_W-1:0]        be_rdata_i,
   output logic                     wtb_pop_o,
   output logic                     fill_ack_o,
   output logic [DATA_W-1:0]        fill_rdata_o,
   output logic                     be_req_o,
   output logic [ADDR_W-BOFF_W-1:0] be_addr_o,
   output logic [DATA_W-1:0]        be_wdata_o,
   output logic [DATA_W/8-1:0]      be_wstrb_o
);

   logic busy;
   logic own_wtb;

   // Grant is held until the backend acks, buffer drains first
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy    <= 1'b0;
         own_wtb <= 1'b0;
      end else if (busy) begin
         if (be_ack_i) begin
            busy <= 1'b0;
         end
      end else if (!wtb_empty_i) begin
         busy    <= 1'b1;
         own_wtb <= 1'b1;
      end else if (fill_req_i) begin
         busy    <= 1'b1;
         own_wtb <= 1'b0;
      end
   end

   assign be_req_o   = busy;
   assign be_addr_o  = own_wtb ? wtb_addr_i[ADDR_W-1:BOFF_W] : fill_addr_i[ADDR_W-1:BOFF_W];
   assign be_wdata_o = wtb_data_i;
   // Fill reads go out with no strobes
   assign be_wstrb_o = own_wtb ? wtb_strb_i : '0;

   assign wtb_pop_o    = busy && own_wtb && be_ack_i;
   assign fill_ack_o   = busy && !own_wtb && be_ack_i;
   assign fill_rdata_o = be_rdata_i;

endmodule

// ==== design/write_through_buf.sv ====
`timescale 1ns/1ps

module write_through_buf #(
   parameter int ADDR_W        = cache_pkg::DEF_ADDR_W,
   parameter int DATA_W        = cache_pkg::DEF_DATA_W,
   parameter int WTBUF_DEPTH_W = cache_pkg::DEF_WTBUF_DEPTH_W
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                push_i,
   input  logic [ADDR_W-1:0]   addr_i,
   input  logic [DATA_W-1:0]   data_i,
   input  logic [DATA_W/8-1:0] strb_i,
   input  logic                pop_i,
   output logic                full_o,
   output logic                empty_o,
   output logic [ADDR_W-1:0]   head_addr_o,
   output logic [DATA_W-1:0]   head_data_o,
   output logic [DATA_W/8-1:0] head_strb_o
);

   localparam int DEPTH = 2 ** WTBUF_DEPTH_W;

   logic [ADDR_W-1:0]        addr_mem [DEPTH];
   logic [DATA_W-1:0]        data_mem [DEPTH];
   logic [DATA_W/8-1:0]      strb_mem [DEPTH];
   logic [WTBUF_DEPTH_W-1:0] wr_ptr;
   logic [WTBUF_DEPTH_W-1:0] rd_ptr;
   logic [WTBUF_DEPTH_W:0]   count;
   logic                     do_push;
   logic                     do_pop;

   // Count reaches DEPTH exactly when its top bit sets
   assign full_o  = count[WTBUF_DEPTH_W];
   assign empty_o = (count == '0);
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   assign head_addr_o = addr_mem[rd_ptr];
   assign head_data_o = data_mem[rd_ptr];
   assign head_strb_o = strb_mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         addr_mem[wr_ptr] <= addr_i;
         data_mem[wr_ptr] <= data_i;
         strb_mem[wr_ptr] <= strb_i;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== design/cache_data_store.sv ====
`timescale 1ns/1ps

module cache_data_store #(
   parameter int DATA_W        = cache_pkg::DEF_DATA_W,
   parameter int NLINES_W      = cache_pkg::DEF_NLINES_W,
   parameter int WORD_OFFSET_W = cache_pkg::DEF_WORD_OFFSET_W,
   localparam int NBYTES       = DATA_W / 8,
   localparam int DADDR_W      = NLINES_W + WORD_OFFSET_W
) (
   input  logic               clk_i,
   input  logic [DADDR_W-1:0] addr_i,
   input  logic               we_i,
   input  logic [NBYTES-1:0]  wstrb_i,
   input  logic [DATA_W-1:0]  wdata_i,
   output logic [DATA_W-1:0]  rd_o
);

   // One entry per word, line index in the upper address bits
   logic [DATA_W-1:0] mem [2**DADDR_W];

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (wstrb_i[b]) begin
               mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
         end
      end
      rd_o <= mem[addr_i];
   end

endmodule

// ==== design/cache_tag_store.sv ====
`timescale 1ns/1ps

module cache_tag_store #(
   parameter int ADDR_W        = cache_pkg::DEF_ADDR_W,
   parameter int DATA_W        = cache_pkg::DEF_DATA_W,
   parameter int NLINES_W      = cache_pkg::DEF_NLINES_W,
   parameter int WORD_OFFSET_W = cache_pkg::DEF_WORD_OFFSET_W,
   localparam int TAG_W        = ADDR_W - NLINES_W - WORD_OFFSET_W - $clog2(DATA_W / 8)
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [NLINES_W-1:0] idx_i,
   input  logic                we_i,
   input  logic [TAG_W-1:0]    wr_tag_i,
   input  logic                invalidate_i,
   output logic [TAG_W-1:0]    rd_tag_o,
   output logic                rd_valid_o
);

   localparam int NLINES = 2 ** NLINES_W;

   logic [TAG_W-1:0]  tag_mem [NLINES];
   logic [NLINES-1:0] valid;

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         tag_mem[idx_i] <= wr_tag_i;
      end
      rd_tag_o <= tag_mem[idx_i];
   end

   // Invalidate wins over a fill completing in the same cycle
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid      <= '0;
         rd_valid_o <= 1'b0;
      end else begin
         if (invalidate_i) begin
            valid <= '0;
         end else if (we_i) begin
            valid[idx_i] <= 1'b1;
         end
         rd_valid_o <= valid[idx_i];
      end
   end

endmodule

// ==== design/cache_pkg.sv ====
package cache_pkg;

   // Default geometry, overridden through the top level parameters
   localparam int DEF_ADDR_W        = 12;
   localparam int DEF_DATA_W        = 32;
   localparam int DEF_NLINES_W      = 4;
   localparam int DEF_WORD_OFFSET_W = 2;
   localparam int DEF_WTBUF_DEPTH_W = 2;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WAIT_WTB,
      FILL,
      FILL_DONE
   } ctrl_state_t;

endpackage
